//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_dcc_capture
FILELIST  = dcc_capture.f
OBJ_DIR   = obj_dir
PASS_MSG  = No errors

SIM = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from the pass line, the simulator exit code alone is not enough
run: compile
	@out="$$(./$(SIM) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- dcc_capture.f
source/dcc_pkg.sv
source/trigger_window.sv
source/window_buffer.sv
source/readout_credit.sv
source/dcc_capture_top.sv
tb/dcc_capture_properties.sv
tb/tb_dcc_capture.sv

//--- source/dcc_capture_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcc_capture_top
    import dcc_pkg::*;
#(
    parameter int num_windows = 4,          // ring depth in windows
    parameter int credit_max  = 8           // credits held after reset
)
(
    input  logic      ADA_DCO,
    input  logic      hps_fpga_reset_n,
    input  sample_t   ada_d,
    input  sample_t   adb_d,
    input  logic      credit_return,
    output logic      out_valid,
    output out_kind_e out_kind,
    output word_t     out_data
);

    // capture -> buffer
    logic                 wr_valid;
    logic                 wr_first;
    word_t                wr_data;
    ts_t                  wr_ts;
    logic                 buffer_full;

    // buffer <-> readout
    logic                 window_ready;
    word_t                rd_word;
    ts_t                  rd_ts;
    logic [idx_width-1:0] rd_index;
    logic                 window_release;

    trigger_window i_trigger_window (
        .ADA_DCO          (ADA_DCO),
        .hps_fpga_reset_n (hps_fpga_reset_n),
        .ada_d            (ada_d),
        .adb_d            (adb_d),
        .buffer_full      (buffer_full),
        .wr_valid         (wr_valid),
        .wr_first         (wr_first),
        .wr_data          (wr_data),
        .wr_ts            (wr_ts)
    );

    window_buffer #(
        .num_windows (num_windows)
    ) i_window_buffer (
        .ADA_DCO          (ADA_DCO),
        .hps_fpga_reset_n (hps_fpga_reset_n),
        .wr_valid         (wr_valid),
        .wr_first         (wr_first),
        .wr_data          (wr_data),
        .wr_ts            (wr_ts),
        .rd_index         (rd_index),
        .window_release   (window_release),
        .buffer_full      (buffer_full),
        .window_ready     (window_ready),
        .rd_word          (rd_word),
        .rd_ts            (rd_ts)
    );

    readout_credit #(
        .credit_max (credit_max)
    ) i_readout_credit (
        .ADA_DCO          (ADA_DCO),
        .hps_fpga_reset_n (hps_fpga_reset_n),
        .window_ready     (window_ready),
        .rd_word          (rd_word),
        .rd_ts            (rd_ts),
        .credit_return    (credit_return),
        .rd_index         (rd_index),
        .window_release   (window_release),
        .out_valid        (out_valid),
        .out_kind         (out_kind),
        .out_data         (out_data)
    );

endmodule

`default_nettype wire

//--- source/dcc_pkg.sv
`default_nettype none

package dcc_pkg;

    ////////////////////////////////////////
    // sizes
    ////////////////////////////////////////
    parameter int sample_width = 14;        // raw adc sample
    parameter int half_width   = 16;        // one channel inside a packed word
    parameter int word_width   = 32;        // a in upper half, b in lower half
    parameter int pre_len      = 4;         // samples kept ahead of the trigger
    parameter int window_len   = 32;        // words per stored window
    parameter int ts_width     = 26;        // sample index width, wraps
    parameter int idx_width    = $clog2(window_len);   // word index within a window

    // trigger level, channel a only
    parameter int trig_threshold = -5400;

    ////////////////////////////////////////
    // types
    ////////////////////////////////////////
    typedef logic signed [sample_width-1:0] sample_t;
    typedef logic [word_width-1:0]          word_t;
    typedef logic [ts_width-1:0]            ts_t;

    typedef enum logic {CAP_IDLE, CAP_ACTIVE} capture_state_e;

    typedef enum logic [1:0] {RD_IDLE, RD_HEADER, RD_DATA} readout_state_e;

    // tags each word on the output stream
    typedef enum logic {KIND_HEADER, KIND_DATA} out_kind_e;

endpackage

`default_nettype wire

//--- source/readout_credit.sv
`timescale 1ns/1ps
`default_nettype none

module readout_credit
    import dcc_pkg::*;
#(
    parameter int credit_max = 8
)
(
    input  logic                 ADA_DCO,
    input  logic                 hps_fpga_reset_n,
    input  logic                 window_ready,
    input  word_t                rd_word,
    input  ts_t                  rd_ts,
    input  logic                 credit_return,     // one credit back per cycle
    output logic [idx_width-1:0] rd_index,
    output logic                 window_release,
    output logic                 out_valid,
    output out_kind_e            out_kind,
    output word_t                out_data
);

    localparam int cred_width = $clog2(credit_max + 1);

    readout_state_e        state;
    logic [cred_width-1:0] credits;         // words we may still send

    ////////////////////////////////////////
    // output word
    ////////////////////////////////////////
    assign out_valid = (state != RD_IDLE) && (credits != '0);   // waits when out of credit
    assign out_kind  = (state == RD_HEADER) ? KIND_HEADER : KIND_DATA;
    assign out_data  = (state == RD_HEADER) ? {{(word_width-ts_width){1'b0}}, rd_ts}
                                            : rd_word;

    // each sent word costs one, each return gives one back
    always_ff @(posedge ADA_DCO or negedge hps_fpga_reset_n)
    begin
        if (!hps_fpga_reset_n)
        begin
            credits <= cred_width'(credit_max);
        end
        else
        begin
            credits <= credits + cred_width'(credit_return) - cred_width'(out_valid);
        end
    end

    ////////////////////////////////////////
    // readout fsm
    ////////////////////////////////////////
    always_ff @(posedge ADA_DCO or negedge hps_fpga_reset_n)
    begin
        if (!hps_fpga_reset_n)
        begin
            state          <= RD_IDLE;
            rd_index       <= '0;
            window_release <= 1'b0;
        end
        else
        begin
            window_release <= 1'b0;
            case (state)
                RD_IDLE:
                begin
                    // skip the release cycle, ready is stale until the slot frees
                    if (window_ready && !window_release)
                    begin
                        state <= RD_HEADER;
                    end
                end
                RD_HEADER:
                begin
                    if (out_valid)
                    begin
                        state    <= RD_DATA;
                        rd_index <= '0;
                    end
                end
                RD_DATA:
                begin
                    if (out_valid)
                    begin
                        if (rd_index == idx_width'(window_len - 1))
                        begin
                            state          <= RD_IDLE;
                            rd_index       <= '0;
                            window_release <= 1'b1;     // one pulse per window
                        end
                        else
                        begin
                            rd_index <= rd_index + 1'b1;
                        end
                    end
                end
                default:
                begin
                    state <= RD_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/trigger_window.sv
`timescale 1ns/1ps
`default_nettype none

module trigger_window
    import dcc_pkg::*;
(
    input  logic    ADA_DCO,
    input  logic    hps_fpga_reset_n,
    input  sample_t ada_d,
    input  sample_t adb_d,
    input  logic    buffer_full,        // only looked at on a trigger
    output logic    wr_valid,
    output logic    wr_first,
    output word_t   wr_data,
    output ts_t     wr_ts
);

    word_t                packed_word;          // current a/b pair
    word_t                pre_line [pre_len];   // [0] newest
    ts_t                  sample_idx;           // index of the sample at this edge
    logic [idx_width-1:0] word_cnt;             // word now on wr_data
    capture_state_e       state;
    logic                 trig_hit;
    logic                 trig_take;

    ////////////////////////////////////////
    // packing and trigger
    ////////////////////////////////////////

    // sign-extend each channel to half_width, a high and b low
    assign packed_word = {{(half_width-sample_width){ada_d[sample_width-1]}}, ada_d,
                          {(half_width-sample_width){adb_d[sample_width-1]}}, adb_d};

    assign trig_hit  = (ada_d <= sample_t'(trig_threshold));   // at or below, signed
    assign trig_take = (state == CAP_IDLE) && trig_hit && !buffer_full;

    ////////////////////////////////////////
    // history and sample index
    ////////////////////////////////////////
    always_ff @(posedge ADA_DCO or negedge hps_fpga_reset_n)
    begin
        if (!hps_fpga_reset_n)
        begin
            for (int i = 0; i < pre_len; i++)
            begin
                pre_line[i] <= '0;          // empty history reads as zero
            end
            sample_idx <= '0;
        end
        else
        begin
            pre_line[0] <= packed_word;
            for (int i = 1; i < pre_len; i++)
            begin
                pre_line[i] <= pre_line[i-1];
            end
            sample_idx <= sample_idx + 1'b1;    // wraps at ts_width
        end
    end

    // oldest history word goes out every cycle, qualified by wr_valid
    always_ff @(posedge ADA_DCO)
    begin
        wr_data <= pre_line[pre_len-1];
        if (trig_take)
        begin
            wr_ts <= sample_idx;            // timestamp = trigger sample index
        end
    end

    ////////////////////////////////////////
    // capture fsm
    ////////////////////////////////////////
    always_ff @(posedge ADA_DCO or negedge hps_fpga_reset_n)
    begin
        if (!hps_fpga_reset_n)
        begin
            state    <= CAP_IDLE;
            word_cnt <= '0;
            wr_valid <= 1'b0;
            wr_first <= 1'b0;
        end
        else
        begin
            wr_first <= 1'b0;               // single cycle marker
            case (state)
                CAP_IDLE:
                begin
                    if (trig_take)
                    begin
                        state    <= CAP_ACTIVE;
                        word_cnt <= '0;
                        wr_valid <= 1'b1;
                        wr_first <= 1'b1;
                    end
                end
                CAP_ACTIVE:
                begin
                    // further triggers only land in the data
                    if (word_cnt == idx_width'(window_len - 1))
                    begin
                        state    <= CAP_IDLE;
                        wr_valid <= 1'b0;   // 32 words done
                    end
                    else
                    begin
                        word_cnt <= word_cnt + 1'b1;
                    end
                end
                default:
                begin
                    state <= CAP_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/window_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module window_buffer
    import dcc_pkg::*;
#(
    parameter int num_windows = 4
)
(
    input  logic                 ADA_DCO,
    input  logic                 hps_fpga_reset_n,
    input  logic                 wr_valid,
    input  logic                 wr_first,
    input  word_t                wr_data,
    input  ts_t                  wr_ts,
    input  logic [idx_width-1:0] rd_index,
    input  logic                 window_release,    // frees the oldest slot
    output logic                 buffer_full,
    output logic                 window_ready,
    output word_t                rd_word,
    output ts_t                  rd_ts
);

    localparam int ptr_width = (num_windows > 1) ? $clog2(num_windows) : 1;
    localparam int cnt_width = $clog2(num_windows + 1);

    word_t                mem [num_windows][window_len];
    ts_t                  ts_mem [num_windows];
    logic [ptr_width-1:0] wr_ptr;               // slot being filled
    logic [ptr_width-1:0] rd_ptr;               // oldest held slot
    logic [idx_width-1:0] wr_word;              // next word within slot
    logic [idx_width-1:0] wr_addr;
    logic [cnt_width-1:0] held;                 // complete windows not yet released
    logic                 last_word;

    // ring step, depth need not be a power of two
    function automatic logic [ptr_width-1:0] next_ptr(input logic [ptr_width-1:0] p);
        return (p == ptr_width'(num_windows - 1)) ? '0 : p + 1'b1;
    endfunction

    assign wr_addr   = wr_first ? '0 : wr_word;     // resync on window start
    assign last_word = wr_valid && (wr_addr == idx_width'(window_len - 1));

    ////////////////////////////////////////
    // storage
    ////////////////////////////////////////
    always_ff @(posedge ADA_DCO)
    begin
        if (wr_valid)
        begin
            mem[wr_ptr][wr_addr] <= wr_data;
            if (wr_first)
            begin
                ts_mem[wr_ptr] <= wr_ts;
            end
        end
    end

    ////////////////////////////////////////
    // pointers and occupancy
    ////////////////////////////////////////
    always_ff @(posedge ADA_DCO or negedge hps_fpga_reset_n)
    begin
        if (!hps_fpga_reset_n)
        begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            wr_word <= '0;
            held    <= '0;
        end
        else
        begin
            if (wr_valid)
            begin
                wr_word <= wr_addr + 1'b1;  // wraps to 0 after the last word
            end
            if (last_word)
            begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (window_release)
            begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // window counts as held from the cycle after its last word
            held <= held + cnt_width'(last_word) - cnt_width'(window_release);
        end
    end

    assign buffer_full  = (held == cnt_width'(num_windows));
    assign window_ready = (held != '0);

    // async read of the oldest window
    assign rd_word = mem[rd_ptr][rd_index];
    assign rd_ts   = ts_mem[rd_ptr];

endmodule

`default_nettype wire

//--- tb/dcc_capture_properties.sv
`timescale 1ns/1ps
`default_nettype none

module dcc_capture_properties
    import dcc_pkg::*;
#(
    parameter int credit_max = 8
)
(
    input logic                              ADA_DCO,
    input logic                              hps_fpga_reset_n,
    input logic                              credit_return,
    input logic                              out_valid,
    input out_kind_e                         out_kind,
    input logic [$clog2(credit_max + 1)-1:0] credits
);

    localparam int cred_width = $clog2(credit_max + 1);

    int   fail_count = 0;       // read by the testbench at the end
    int   data_cnt;             // data words since the last header
    logic in_window;            // a header has been seen
    int   credit_model;         // credits rebuilt from port traffic

    always_ff @(posedge ADA_DCO or negedge hps_fpga_reset_n)
    begin
        if (!hps_fpga_reset_n)
        begin
            data_cnt     <= 0;
            in_window    <= 1'b0;
            credit_model <= credit_max;
        end
        else
        begin
            credit_model <= credit_model + (credit_return ? 1 : 0) - (out_valid ? 1 : 0);
            if (out_valid)
            begin
                if (out_kind == KIND_HEADER)
                begin
                    data_cnt  <= 0;
                    in_window <= 1'b1;
                end
                else
                begin
                    data_cnt <= data_cnt + 1;
                end
            end
        end
    end

    ////////////////////////////////////////
    // credit rules
    ////////////////////////////////////////
    a_send_needs_credit: assert property (@(posedge ADA_DCO) disable iff (!hps_fpga_reset_n)
        out_valid |-> credit_model > 0)
        else begin fail_count++; $error("word sent with zero credits"); end

    a_credit_bound: assert property (@(posedge ADA_DCO) disable iff (!hps_fpga_reset_n)
        credits <= cred_width'(credit_max))
        else begin fail_count++; $error("credit count above its maximum"); end

    a_quiet_in_reset: assert property (@(posedge ADA_DCO)
        !hps_fpga_reset_n |-> !out_valid)
        else begin fail_count++; $error("out_valid high during reset"); end

    ////////////////////////////////////////
    // framing, header then 32 data words
    ////////////////////////////////////////
    a_header_spacing: assert property (@(posedge ADA_DCO) disable iff (!hps_fpga_reset_n)
        out_valid && out_kind == KIND_HEADER && in_window |-> data_cnt == window_len)
        else begin fail_count++; $error("header before the previous window ended"); end

    a_data_in_window: assert property (@(posedge ADA_DCO) disable iff (!hps_fpga_reset_n)
        out_valid && out_kind == KIND_DATA |-> in_window && data_cnt < window_len)
        else begin fail_count++; $error("data word outside a window"); end

endmodule

bind readout_credit dcc_capture_properties #(
    .credit_max (credit_max)
) i_credit_props (
    .ADA_DCO          (ADA_DCO),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .credit_return    (credit_return),
    .out_valid        (out_valid),
    .out_kind         (out_kind),
    .credits          (credits)
);

`default_nettype wire

//--- tb/tb_dcc_capture.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dcc_capture
    import dcc_pkg::*;
();

    localparam int clk_period   = 100;
    localparam int tb_windows   = 4;
    localparam int tb_credits   = 8;
    localparam int reset_cycles = 16;
    localparam int gap_cycles   = 40;       // longer than a capture
    localparam int stim_cycles  = reset_cycles + 3 * (gap_cycles + 24) + 6 * (gap_cycles + 1)
                                  + 5 * (gap_cycles + 16) + 5 * 8;
    localparam int drain_cycles = 5 * tb_windows * (window_len + 1) * 8;  // slow credits
    localparam int watchdog_ns  = (stim_cycles + drain_cycles) * clk_period;

    logic      ADA_DCO = 1'b0;
    logic      hps_fpga_reset_n;
    sample_t   ada_d;
    sample_t   adb_d;
    logic      credit_return = 1'b0;
    logic      out_valid;
    out_kind_e out_kind;
    word_t     out_data;

    logic [31:0] stim_lfsr;                 // sample stream
    logic [31:0] delay_lfsr;                // credit delays
    word_t       hist [pre_len];            // [0] newest
    ts_t         ref_idx = '0;
    int          busy_left = 0;             // edges until capture idles
    int          post_left = 0;             // post-trigger words still to queue
    int          accepted = 0;
    int          rel_applied = 0;           // releases the full flag has seen
    int          releases = 0;
    out_kind_e   exp_kind [$];
    word_t       exp_data [$];
    int          credits_held = tb_credits;
    int          owed = 0;                  // received words not yet credited
    int          delay_left = 0;
    int          data_cnt = 0;
    int          words_seen = 0;
    int          base_words;
    logic        allow_credits = 1'b1;
    logic        random_delay = 1'b0;
    int          mismatch_errors = 0;
    int          other_errors = 0;

    dcc_capture_top #(
        .num_windows (tb_windows),
        .credit_max  (tb_credits)
    ) i_dut (
        .ADA_DCO          (ADA_DCO),
        .hps_fpga_reset_n (hps_fpga_reset_n),
        .ada_d            (ada_d),
        .adb_d            (adb_d),
        .credit_return    (credit_return),
        .out_valid        (out_valid),
        .out_kind         (out_kind),
        .out_data         (out_data)
    );

    always #(clk_period / 2) ADA_DCO = ~ADA_DCO;

    ////////////////////////////////////////
    // random source
    ////////////////////////////////////////
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};     // taps 32 22 2 1
    endfunction

    function automatic logic [31:0] take_bits(inout logic [31:0] st, input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            st = lfsr_next(st);
            r  = {r[30:0], st[0]};          // one step per bit
        end
        return r;
    endfunction

    function automatic sample_t any_sample();
        return sample_t'(take_bits(stim_lfsr, sample_width));
    endfunction

    // random but above the trigger level
    function automatic sample_t quiet_sample();
        sample_t s;
        s = any_sample();
        if (int'(s) <= trig_threshold)
        begin
            s = sample_t'(int'(s) - trig_threshold);
        end
        return s;
    endfunction

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////
    function automatic word_t pack_pair(input sample_t a, input sample_t b);
        logic signed [half_width-1:0] ea;
        logic signed [half_width-1:0] eb;
        ea = half_width'(a);                // signed cast keeps the sign
        eb = half_width'(b);
        return {ea, eb};
    endfunction

    function automatic void ref_step(input sample_t a, input sample_t b);
        word_t w;
        w = pack_pair(a, b);
        if (busy_left > 0)
        begin
            busy_left--;
            if (post_left > 0)
            begin
                exp_kind.push_back(KIND_DATA);
                exp_data.push_back(w);
                post_left--;
            end
        end
        else if (int'(a) <= trig_threshold && accepted - rel_applied < tb_windows)
        begin
            exp_kind.push_back(KIND_HEADER);
            exp_data.push_back(word_t'(ref_idx));
            for (int i = pre_len - 1; i >= 0; i--)
            begin
                exp_kind.push_back(KIND_DATA);      // oldest history first
                exp_data.push_back(hist[i]);
            end
            exp_kind.push_back(KIND_DATA);
            exp_data.push_back(w);
            post_left = window_len - pre_len - 1;
            busy_left = window_len;
            accepted++;
        end
        rel_applied = releases;             // full flag lags a release by one edge
        for (int i = pre_len - 1; i > 0; i--)
        begin
            hist[i] = hist[i-1];
        end
        hist[0] = w;
        ref_idx = ref_idx + ts_t'(1);
    endfunction

    always @(posedge ADA_DCO)
    begin
        if (hps_fpga_reset_n)
        begin
            ref_step(ada_d, adb_d);
        end
    end

    ////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////
    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp)
        begin
            mismatch_errors++;
            $display("FAIL %0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_kind(input string name, input out_kind_e exp, input out_kind_e act);
        if (act !== exp)
        begin
            mismatch_errors++;
            $display("FAIL %0t %s expected %s got %s", $time, name, exp.name(), act.name());
        end
    endtask

    task automatic check_ts(input ts_t exp, input word_t act);
        if (act !== {{(word_width-ts_width){1'b0}}, exp})
        begin
            mismatch_errors++;
            $display("FAIL %0t out_data(header) expected %h got %h", $time, exp, act);
        end
    endtask

    ////////////////////////////////////////
    // consumer and compare
    ////////////////////////////////////////
    always @(posedge ADA_DCO)
    begin
        out_kind_e k;
        word_t     w;
        if (hps_fpga_reset_n)
        begin
            if (out_valid)
            begin
                if (credits_held == 0)
                begin
                    other_errors++;
                    $display("word arrived at %0t although no credit was held", $time);
                end
                words_seen++;
                owed++;
                if (exp_kind.size() == 0)
                begin
                    other_errors++;
                    $display("word arrived at %0t when no window was expected", $time);
                end
                else
                begin
                    k = exp_kind.pop_front();
                    w = exp_data.pop_front();
                    check_kind("out_kind", k, out_kind);
                    if (k == KIND_HEADER)
                    begin
                        check_ts(ts_t'(w), out_data);
                        data_cnt = 0;
                    end
                    else
                    begin
                        check_word("out_data", w, out_data);
                        data_cnt++;
                        if (data_cnt == window_len)
                        begin
                            releases <= releases + 1;   // slot frees next edge
                        end
                    end
                end
            end
            credits_held = credits_held + (credit_return ? 1 : 0) - (out_valid ? 1 : 0);
            // hand credits back, one per cycle at most
            if (allow_credits && owed > 0 && delay_left == 0)
            begin
                credit_return <= 1'b1;
                owed--;
                delay_left = random_delay ? int'(take_bits(delay_lfsr, 3)) : 0;
            end
            else
            begin
                credit_return <= 1'b0;
                if (delay_left > 0)
                begin
                    delay_left--;
                end
            end
        end
    end

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////
    task automatic drive_pair(input sample_t a, input sample_t b);
        @(posedge ADA_DCO);
        ada_d <= a;
        adb_d <= b;
    endtask

    task automatic idle_samples(input int n);
        for (int i = 0; i < n; i++)
        begin
            drive_pair(quiet_sample(), any_sample());   // b may sit below the level
        end
    endtask

    // all words read and all credits back
    task automatic wait_drain();
        do
        begin
            @(negedge ADA_DCO);
        end
        while (exp_kind.size() != 0 || owed != 0 || post_left != 0);
        repeat (4) @(negedge ADA_DCO);      // release pulse and last credit
    endtask

    initial
    begin
        stim_lfsr        = 32'd74109;
        delay_lfsr       = 32'd74109;
        hps_fpga_reset_n = 1'b0;
        ada_d            = '0;
        adb_d            = '0;
        for (int i = 0; i < pre_len; i++)
        begin
            hist[i] = '0;                   // nothing sampled yet
        end
        repeat (reset_cycles) @(posedge ADA_DCO);
        hps_fpga_reset_n <= 1'b1;

        // single window
        idle_samples(10);
        drive_pair(sample_t'(-6000), any_sample());
        idle_samples(gap_cycles);
        wait_drain();

        // threshold edge, b alone never fires
        drive_pair(sample_t'(trig_threshold + 1), any_sample());
        idle_samples(3);
        drive_pair(quiet_sample(), sample_t'(-8000));
        idle_samples(3);
        drive_pair(sample_t'(trig_threshold), any_sample());
        idle_samples(gap_cycles);
        wait_drain();

        // low samples inside a capture
        drive_pair(sample_t'(-7000), any_sample());
        idle_samples(6);
        drive_pair(sample_t'(-8000), any_sample());
        idle_samples(10);
        drive_pair(sample_t'(trig_threshold), any_sample());
        idle_samples(gap_cycles);
        wait_drain();

        ////////////////////////////////////////
        // full buffer, no credits back
        ////////////////////////////////////////
        allow_credits = 1'b0;
        base_words    = words_seen;
        repeat (6)
        begin
            drive_pair(sample_t'(-6500), any_sample());
            idle_samples(gap_cycles);
        end
        @(negedge ADA_DCO);
        if (words_seen - base_words != tb_credits)
        begin
            other_errors++;
            $display("stalled stream sent %0d words for %0d credits",
                     words_seen - base_words, tb_credits);
        end
        allow_credits = 1'b1;
        wait_drain();

        // back-pressure with random credit delays
        random_delay = 1'b1;
        repeat (5)
        begin
            drive_pair(sample_t'(-6000), any_sample());
            idle_samples(gap_cycles + int'(take_bits(stim_lfsr, 4)));
        end
        wait_drain();

        $display("closing: %0d value mismatches, %0d other errors, %0d assertion failures",
                 mismatch_errors, other_errors,
                 i_dut.i_readout_credit.i_credit_props.fail_count);
        if (mismatch_errors + other_errors
            + i_dut.i_readout_credit.i_credit_props.fail_count == 0)
        begin
            $display("No errors");
        end
        else
        begin
            $display("Errors found");
        end
        $finish;
    end

    // watchdog
    initial
    begin
        #(watchdog_ns);
        $display("timeout: output stream did not drain, %0d words still expected",
                 exp_kind.size());
        $display("closing: %0d value mismatches, %0d other errors", mismatch_errors,
                 other_errors);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire
